// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    parameter int XLEN       = 32;
    parameter int LINE_WORDS = 8;
    parameter int REG_ADDR_W = 5;

    // major opcodes
    parameter logic [5:0] OP_SPECIAL  = 6'h00;
    parameter logic [5:0] OP_REGIMM   = 6'h01;
    parameter logic [5:0] OP_J        = 6'h02;
    parameter logic [5:0] OP_JAL      = 6'h03;
    parameter logic [5:0] OP_BEQ      = 6'h04;
    parameter logic [5:0] OP_BNE      = 6'h05;
    parameter logic [5:0] OP_BLEZ     = 6'h06;
    parameter logic [5:0] OP_BGTZ     = 6'h07;
    parameter logic [5:0] OP_LUI      = 6'h0f;
    parameter logic [5:0] OP_COP0     = 6'h10;
    parameter logic [5:0] OP_BEQL     = 6'h14;
    parameter logic [5:0] OP_BNEL     = 6'h15;
    parameter logic [5:0] OP_BLEZL    = 6'h16;
    parameter logic [5:0] OP_BGTZL    = 6'h17;
    parameter logic [5:0] OP_SPECIAL2 = 6'h1c;
    parameter logic [5:0] OP_LB       = 6'h20;
    parameter logic [5:0] OP_LH       = 6'h21;
    parameter logic [5:0] OP_LWL      = 6'h22;
    parameter logic [5:0] OP_LW       = 6'h23;
    parameter logic [5:0] OP_LBU      = 6'h24;
    parameter logic [5:0] OP_LHU      = 6'h25;
    parameter logic [5:0] OP_LWR      = 6'h26;
    parameter logic [5:0] OP_SB       = 6'h28;
    parameter logic [5:0] OP_SH       = 6'h29;
    parameter logic [5:0] OP_SWL      = 6'h2a;
    parameter logic [5:0] OP_SW       = 6'h2b;
    parameter logic [5:0] OP_SWR      = 6'h2e;

    // special function codes
    parameter logic [5:0] FN_SLL     = 6'h00;
    parameter logic [5:0] FN_SRL     = 6'h02;
    parameter logic [5:0] FN_SRA     = 6'h03;
    parameter logic [5:0] FN_JR      = 6'h08;
    parameter logic [5:0] FN_JALR    = 6'h09;
    parameter logic [5:0] FN_SYSCALL = 6'h0c;
    parameter logic [5:0] FN_BREAK   = 6'h0d;
    parameter logic [5:0] FN_SYNC    = 6'h0f;
    parameter logic [5:0] FN_MFHI    = 6'h10;
    parameter logic [5:0] FN_MTHI    = 6'h11;
    parameter logic [5:0] FN_MFLO    = 6'h12;
    parameter logic [5:0] FN_MTLO    = 6'h13;
    parameter logic [5:0] FN_MULT    = 6'h18;
    parameter logic [5:0] FN_MULTU   = 6'h19;
    parameter logic [5:0] FN_DIV     = 6'h1a;
    parameter logic [5:0] FN_DIVU    = 6'h1b;
    // special2 and cop0
    parameter logic [5:0] FN_MUL     = 6'h02;
    parameter logic [5:0] FN_TLBR    = 6'h01;
    parameter logic [5:0] FN_TLBWI   = 6'h02;
    parameter logic [5:0] FN_TLBWR   = 6'h06;
    parameter logic [5:0] FN_TLBP    = 6'h08;

    parameter logic [REG_ADDR_W-1:0] RS_MF = 5'h00;
    parameter logic [REG_ADDR_W-1:0] RS_MT = 5'h04;
    parameter logic [REG_ADDR_W-1:0] RS_CO = 5'h10;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            sa;
        logic [5:0]            func;
    } r_form_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_u;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            no_inst;
    } fetch_req_t;

    typedef struct packed {
        logic [3:0]                       data_num;
        logic [LINE_WORDS-1:0][XLEN-1:0]  rdata;
    } cache_resp_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_word_u      inst;
    } issue_slot_t;

    typedef struct packed {
        issue_slot_t slot0;
        issue_slot_t slot1;
        logic        dual;
    } issue_pair_t;

    typedef struct packed {
        logic                  is_branch;
        logic                  is_load_like;
        logic                  is_muldiv;
        logic                  is_tlb;
        logic                  reads_rs;
        logic                  reads_rt;
        logic [REG_ADDR_W-1:0] dest;
    } inst_class_t;

endpackage

// ==== src/fetch_ctrl.sv ====
module fetch_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    output logic       in_allowin,
    input  logic       no_inst,
    input  logic       queue_has_room,
    input  logic       data_ok,
    input  logic [3:0] data_num,
    input  logic       flush,
    output logic       write_line,
    output logic       write_nop,
    output logic       accept,
    output logic       draining,
    output logic [5:0] fetch_offset
);

    localparam logic [3:0] S_WAIT   = 4'b0001;
    localparam logic [3:0] S_RECV   = 4'b0010;
    localparam logic [3:0] S_NOINST = 4'b0100;
    localparam logic [3:0] S_DRAIN  = 4'b1000;

    logic [3:0] state;
    logic [3:0] state_next;

    // one outstanding request, and only with a full line of space
    assign in_allowin = (state == S_WAIT) && queue_has_room;
    assign accept     = in_valid && in_allowin;

    assign write_line = (state == S_RECV) && data_ok && !flush;
    assign write_nop  = (state == S_NOINST) && !flush;
    assign draining   = (state == S_DRAIN);

    always_comb begin
        state_next = state;
        case (state)
            S_WAIT: begin
                // a request taken in the flush cycle still goes to receive
                if (accept && (flush || !no_inst))
                    state_next = S_RECV;
                else if (accept)
                    state_next = S_NOINST;
            end
            S_RECV: begin
                if (data_ok)
                    state_next = S_WAIT;
                else if (flush)
                    state_next = S_DRAIN;
            end
            S_NOINST: state_next = S_WAIT;
            S_DRAIN: begin
                // response of the flushed request is dropped here
                if (data_ok)
                    state_next = S_WAIT;
            end
            default: state_next = S_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= S_WAIT;
        else
            state <= state_next;
    end

    // byte step to the next fetch pc
    always_ff @(posedge clk) begin
        if (reset || flush)
            fetch_offset <= 6'd4;
        else if (write_line)
            fetch_offset <= {data_num, 2'b00};
    end

endmodule

// ==== inst_queue/inst_queue.sv ====
module inst_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        accept,
    input  fetch_req_t  req,
    input  logic        write_line,
    input  logic        write_nop,
    input  cache_resp_t resp,
    input  logic        flush,
    input  logic        pop,
    input  logic        pop_two,
    output logic        has_room,
    output logic        ready,
    output issue_slot_t head_slot0,
    output issue_slot_t head_slot1
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    // one extra bit tells full from empty
    localparam int CNT_W = PTR_W + 1;

    issue_slot_t           mem [QUEUE_DEPTH];
    logic [XLEN-1:0]       line_pc;
    logic [CNT_W-1:0]      head;
    logic [CNT_W-1:0]      tail;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      wr_count;
    logic [PTR_W-1:0]      head_idx;
    logic [PTR_W-1:0]      head_idx1;
    logic [PTR_W-1:0]      wr_idx [LINE_WORDS];
    logic [LINE_WORDS-1:0] wr_en;

    always_ff @(posedge clk) begin
        if (accept)
            line_pc <= req.pc;
    end

    // a no-instruction fetch fills two slots with zero words
    always_comb begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            wr_idx[i] = tail[PTR_W-1:0] + PTR_W'(i);
            wr_en[i]  = (write_line && i < int'(resp.data_num)) || (write_nop && i < 2);
        end
    end

    assign wr_count = write_nop ? CNT_W'(2) : CNT_W'(resp.data_num);

    always_ff @(posedge clk) begin
        for (int i = 0; i < LINE_WORDS; i++) begin
            if (wr_en[i]) begin
                mem[wr_idx[i]].pc   <= line_pc + XLEN'(4 * i);
                mem[wr_idx[i]].inst <= write_nop ? '0 : resp.rdata[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            tail <= '0;
        else if (write_line || write_nop)
            tail <= tail + wr_count;
    end

    always_ff @(posedge clk) begin
        if (reset || flush)
            head <= '0;
        else if (pop)
            head <= head + (pop_two ? CNT_W'(2) : CNT_W'(1));
    end

    assign count    = tail - head;
    assign has_room = count <= CNT_W'(QUEUE_DEPTH - LINE_WORDS);
    // pairing needs both head words present
    assign ready    = count >= CNT_W'(2);

    assign head_idx   = head[PTR_W-1:0];
    assign head_idx1  = head_idx + PTR_W'(1);
    assign head_slot0 = mem[head_idx];
    assign head_slot1 = mem[head_idx1];

endmodule

// ==== issue/inst_classify.sv ====
module inst_classify
    import fetch_pkg::*;
(
    input  inst_word_u  inst,
    output inst_class_t cls
);

    logic [5:0]            op;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic [REG_ADDR_W-1:0] rd;
    logic [4:0]            sa;
    logic [5:0]            func;
    logic                  is_load;
    logic                  is_store;
    logic                  is_mfc0;
    logic                  is_mtc0;
    logic                  is_hilo_read;
    logic                  is_mul;
    logic                  is_md;
    logic                  is_jump_reg;
    logic                  cop0_co;
    logic                  is_branch;
    logic                  reads_rs;
    logic                  reads_rt;

    assign op   = inst.i_form.op;
    assign rs   = inst.i_form.rs;
    assign rt   = inst.i_form.rt;
    assign rd   = inst.r_form.rd;
    assign sa   = inst.r_form.sa;
    assign func = inst.r_form.func;

    assign is_load  = op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};
    assign is_store = op inside {OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR};

    assign is_mfc0 = op == OP_COP0 && rs == RS_MF && sa == '0 && func[5:3] == '0;
    assign is_mtc0 = op == OP_COP0 && rs == RS_MT && sa == '0 && func[5:3] == '0;
    assign cop0_co = op == OP_COP0 && rs == RS_CO && rt == '0 && rd == '0 && sa == '0;

    assign is_hilo_read = op == OP_SPECIAL && func inside {FN_MFHI, FN_MFLO}
                          && rs == '0 && rt == '0 && sa == '0;
    assign is_mul = op == OP_SPECIAL2 && func == FN_MUL && sa == '0;
    assign is_md  = op == OP_SPECIAL && func inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU}
                    && rd == '0 && sa == '0;

    assign is_jump_reg = (func == FN_JR && rt == '0 && rd == '0 && sa == '0)
                         || (func == FN_JALR && rt == '0 && sa == '0);

    always_comb begin
        is_branch = 1'b0;
        reads_rs  = 1'b0;
        reads_rt  = 1'b0;
        case (op)
            OP_SPECIAL: begin
                is_branch = is_jump_reg;
                reads_rs  = !(func inside {FN_SLL, FN_SRL, FN_SRA, FN_SYSCALL, FN_BREAK,
                                           FN_SYNC, FN_MFHI, FN_MFLO});
                reads_rt  = !(func inside {FN_JR, FN_JALR, FN_SYSCALL, FN_BREAK, FN_SYNC,
                                           FN_MFHI, FN_MTHI, FN_MFLO, FN_MTLO});
            end
            OP_REGIMM: begin
                // rt[3] set marks the trap-immediate group
                is_branch = rt[3:2] == 2'b00;
                reads_rs  = 1'b1;
            end
            OP_J, OP_JAL: is_branch = 1'b1;
            OP_BEQ, OP_BNE, OP_BEQL, OP_BNEL: begin
                is_branch = 1'b1;
                reads_rs  = 1'b1;
                reads_rt  = 1'b1;
            end
            OP_BLEZ, OP_BGTZ, OP_BLEZL, OP_BGTZL: begin
                is_branch = rt == '0;
                reads_rs  = 1'b1;
            end
            OP_SPECIAL2: begin
                reads_rs = is_mul;
                reads_rt = is_mul;
            end
            OP_COP0: reads_rt = is_mtc0;
            default: begin
                // immediate alu ops other than lui, then memory ops
                reads_rs = (op[5:3] == 3'b001 && op != OP_LUI) || is_load || is_store;
                reads_rt = is_store || op == OP_LWL || op == OP_LWR;
            end
        endcase
    end

    assign cls = '{
        is_branch:    is_branch,
        is_load_like: is_load || is_mfc0 || is_hilo_read,
        is_muldiv:    is_mul || is_md,
        is_tlb:       cop0_co && func inside {FN_TLBP, FN_TLBR, FN_TLBWI, FN_TLBWR},
        reads_rs:     reads_rs,
        reads_rt:     reads_rt,
        dest:         is_hilo_read ? rd : rt
    };

endmodule

// ==== issue/pair_issue.sv ====
module pair_issue
    import fetch_pkg::*;
(
    input  issue_slot_t slot0_in,
    input  issue_slot_t slot1_in,
    output issue_pair_t pair,
    output logic        pop_two
);

    inst_class_t           cls0;
    inst_class_t           cls1;
    inst_word_u            slot1_inst;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rt1;
    logic                  rs_hazard;
    logic                  rt_hazard;
    logic                  load_use;
    logic                  both_muldiv;
    logic                  any_tlb;
    logic                  single;

    inst_classify i_classify0 (
        .inst (slot0_in.inst),
        .cls  (cls0)
    );

    inst_classify i_classify1 (
        .inst (slot1_in.inst),
        .cls  (cls1)
    );

    assign rs1 = slot1_in.inst.r_form.rs;
    assign rt1 = slot1_in.inst.r_form.rt;

    // slot1 cannot use a value that slot0 only has late
    assign rs_hazard = cls1.reads_rs && rs1 == cls0.dest;
    assign rt_hazard = cls1.reads_rt && rt1 == cls0.dest;
    assign load_use  = cls0.is_load_like && cls0.dest != '0 && (rs_hazard || rt_hazard);

    // one multiply/divide unit
    assign both_muldiv = cls0.is_muldiv && cls1.is_muldiv;
    assign any_tlb     = cls0.is_tlb || cls1.is_tlb;

    // a branch in slot1 would lose its delay slot pairing
    assign single = cls1.is_branch || load_use || both_muldiv || any_tlb;

    assign slot1_inst = slot1_in.inst & {XLEN{!single}};

    assign pair = '{
        slot0: slot0_in,
        slot1: '{pc: slot1_in.pc, inst: slot1_inst},
        dual:  !single
    };

    assign pop_two = !single;

endmodule

// ==== src/fetch_stage.sv ====
module fetch_stage
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_allowin,
    input  fetch_req_t  req,
    input  logic        data_ok,
    input  cache_resp_t resp,
    input  logic        flush,
    output logic        out_valid,
    input  logic        ds_allowin,
    output issue_pair_t pair,
    output logic [5:0]  fetch_offset
);

    logic        accept;
    logic        write_line;
    logic        write_nop;
    logic        draining;
    logic        has_room;
    logic        ready;
    logic        pop;
    logic        pop_two;
    issue_slot_t head_slot0;
    issue_slot_t head_slot1;

    fetch_ctrl i_fetch_ctrl (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_allowin     (in_allowin),
        .no_inst        (req.no_inst),
        .queue_has_room (has_room),
        .data_ok        (data_ok),
        .data_num       (resp.data_num),
        .flush          (flush),
        .write_line     (write_line),
        .write_nop      (write_nop),
        .accept         (accept),
        .draining       (draining),
        .fetch_offset   (fetch_offset)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_inst_queue (
        .clk        (clk),
        .reset      (reset),
        .accept     (accept),
        .req        (req),
        .write_line (write_line),
        .write_nop  (write_nop),
        .resp       (resp),
        .flush      (flush),
        .pop        (pop),
        .pop_two    (pop_two),
        .has_room   (has_room),
        .ready      (ready),
        .head_slot0 (head_slot0),
        .head_slot1 (head_slot1)
    );

    pair_issue i_pair_issue (
        .slot0_in (head_slot0),
        .slot1_in (head_slot1),
        .pair     (pair),
        .pop_two  (pop_two)
    );

    // nothing leaves while the queue is being discarded
    assign out_valid = ready && !flush && !draining;
    assign pop       = out_valid && ds_allowin;

endmodule

// ==== verif/clock_gen.sv ====
module clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = !clk;
    end

    // held over two rising edges, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

// ==== verif/fetch_stage_asserts.sv ====
module fetch_stage_asserts
    import fetch_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic        in_valid,
    input logic        out_valid,
    input logic        ds_allowin,
    input logic        in_allowin,
    input issue_pair_t pair,
    input logic [3:0]  ctrl_state
);

    // one-hot wait encoding of fetch_ctrl
    localparam logic [3:0] WAIT_STATE = 4'b0001;

    // queue is empty in the cycle after a flush
    no_issue_during_flush: assert property (
        @(posedge clk) disable iff (reset) flush |-> !out_valid ##1 !out_valid
    ) else $error("out_valid high during or just after a flush");

    pair_held_on_stall: assert property (
        @(posedge clk) disable iff (reset) out_valid && !ds_allowin |=> $stable(pair)
    ) else $error("pair changed while downstream held it");

    allowin_drops_after_accept: assert property (
        @(posedge clk) disable iff (reset)
        in_valid && in_allowin |=> ctrl_state != WAIT_STATE && !in_allowin
    ) else $error("in_allowin still high after a request was taken");

endmodule

bind fetch_stage fetch_stage_asserts i_fetch_stage_asserts (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .ds_allowin (ds_allowin),
    .in_allowin (in_allowin),
    .pair       (pair),
    .ctrl_state (i_fetch_ctrl.state)
);

// ==== verif/tb_fetch_stage.sv ====
module tb_fetch_stage;
    import fetch_pkg::*;

    localparam int QUEUE_DEPTH = 16;
    localparam int NUM_REQS    = 80;

    typedef enum int {
        K_NOP, K_ADDU, K_LW, K_BEQ, K_J, K_MULT, K_MUL, K_TLB, K_MFHI
    } word_kind_e;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_allowin;
    fetch_req_t  req;
    logic        data_ok;
    cache_resp_t resp;
    logic        flush;
    logic        out_valid;
    logic        ds_allowin;
    issue_pair_t pair;
    logic [5:0]  fetch_offset;

    integer          seed       = 32'h896;
    integer          stall_seed = 32'h896;
    logic            drain_all  = 1'b0;
    logic [XLEN-1:0] exp_pc[$];
    logic [XLEN-1:0] exp_word[$];
    logic [5:0]      exp_offset = 6'd4;
    logic [XLEN-1:0] pend_pc    = '0;
    logic            pend_line  = 1'b0;
    logic            stale      = 1'b0;
    logic            nop_next   = 1'b0;

    clock_gen #(.PERIOD(100)) i_clock_gen (.clk(clk), .reset(reset));

    fetch_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_fetch_stage (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_allowin   (in_allowin),
        .req          (req),
        .data_ok      (data_ok),
        .resp         (resp),
        .flush        (flush),
        .out_valid    (out_valid),
        .ds_allowin   (ds_allowin),
        .pair         (pair),
        .fetch_offset (fetch_offset)
    );

    task automatic end_in_failure();
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string what);
        $display("FAILED at time %0t: %s", $time, what);
        end_in_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        end_in_failure();
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #10;
    endtask

    // only the encodings that make_word produces
    function automatic word_kind_e word_kind(input logic [XLEN-1:0] w);
        case (w[31:26])
            6'h23: return K_LW;
            6'h04: return K_BEQ;
            6'h02: return K_J;
            6'h1c: return K_MUL;
            6'h10: return K_TLB;
            default: begin
                if (w == '0)
                    return K_NOP;
                if (w[5:0] == 6'h21)
                    return K_ADDU;
                if (w[5:0] == 6'h18)
                    return K_MULT;
                return K_MFHI;
            end
        endcase
    endfunction

    function automatic logic expect_dual(input logic [XLEN-1:0] w0, input logic [XLEN-1:0] w1);
        word_kind_e k0;
        word_kind_e k1;
        logic [4:0] dest0;
        logic       rs_used;
        logic       rt_used;
        k0 = word_kind(w0);
        k1 = word_kind(w1);
        dest0 = (k0 == K_MFHI) ? w0[15:11] : w0[20:16];
        rs_used = k1 inside {K_ADDU, K_LW, K_BEQ, K_MULT, K_MUL};
        rt_used = k1 inside {K_ADDU, K_BEQ, K_MULT, K_MUL, K_NOP};
        if (k1 inside {K_BEQ, K_J})
            return 1'b0;
        if (k0 == K_TLB || k1 == K_TLB)
            return 1'b0;
        if (k0 inside {K_MULT, K_MUL} && k1 inside {K_MULT, K_MUL})
            return 1'b0;
        if (k0 inside {K_LW, K_MFHI} && dest0 != '0
                && ((rs_used && w1[25:21] == dest0) || (rt_used && w1[20:16] == dest0)))
            return 1'b0;
        return 1'b1;
    endfunction

    // registers kept to 0..7 so hazards come up often
    function automatic logic [XLEN-1:0] make_word();
        int         kind;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        kind = $random(seed) & 15;
        rs = 5'($random(seed) & 7);
        rt = 5'($random(seed) & 7);
        rd = 5'($random(seed) & 7);
        case (kind)
            1: return {6'h23, rs, rt, 16'($random(seed))};
            2: return {6'h04, rs, rt, 16'h0004};
            3: return {6'h02, 26'($random(seed))};
            4: return {6'h00, rs, rt, 10'd0, 6'h18};
            5: return {6'h1c, rs, rt, rd, 5'd0, 6'h02};
            6: return 32'h4200_0002;
            7: return {6'h00, 10'd0, rd, 5'd0, 6'h10};
            default: return {6'h00, rs, rt, rd, 5'd0, 6'h21};
        endcase
    endfunction

    task automatic push_word(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] word);
        exp_pc.push_back(pc);
        exp_word.push_back(word);
    endtask

    task automatic send_request();
        int   tries;
        logic taken;
        tries = 0;
        taken = 1'b0;
        in_valid = 1'b1;
        req.pc = $random(seed);
        req.pc[1:0] = 2'b00;
        req.no_inst = ($random(seed) & 7) == 0;
        while (!taken) begin
            @(posedge clk);
            taken = in_allowin;
            #10;
            tries++;
            if (!taken && tries > 200)
                report_problem("fetch request not accepted within 200 cycles");
        end
        in_valid = 1'b0;
    endtask

    task automatic answer_request();
        int delay;
        int flush_slot;
        delay = $random(seed) & 7;
        flush_slot = $random(seed) & 31;
        // a flush here leaves the response outstanding
        for (int n = 0; n < delay; n++) begin
            flush = (n == flush_slot);
            step_cycle();
        end
        flush = 1'b0;
        data_ok = 1'b1;
        resp.data_num = 4'(1 + ($random(seed) & 7));
        for (int i = 0; i < LINE_WORDS; i++)
            resp.rdata[i] = make_word();
        step_cycle();
        data_ok = 1'b0;
    endtask

    task automatic check_transfer();
        logic want;
        assert (exp_pc.size() >= 2)
            else report_problem("downstream transfer with fewer than two words queued");
        want = expect_dual(exp_word[0], exp_word[1]);
        assert (pair.slot0.pc == exp_pc[0] && pair.slot0.inst == exp_word[0])
            else report_mismatch($sformatf("slot0 pc %h inst %h, expected pc %h inst %h",
                pair.slot0.pc, pair.slot0.inst, exp_pc[0], exp_word[0]));
        assert (pair.dual == want)
            else report_mismatch($sformatf("dual %b for %h then %h, expected %b",
                pair.dual, exp_word[0], exp_word[1], want));
        if (want) begin
            assert (pair.slot1.pc == exp_pc[1] && pair.slot1.inst == exp_word[1])
                else report_mismatch($sformatf("slot1 pc %h inst %h, expected pc %h inst %h",
                    pair.slot1.pc, pair.slot1.inst, exp_pc[1], exp_word[1]));
            void'(exp_pc.pop_front());
            void'(exp_word.pop_front());
        end else begin
            assert (pair.slot1.inst == '0)
                else report_mismatch($sformatf("slot1 inst %h on single issue",
                    pair.slot1.inst));
        end
        void'(exp_pc.pop_front());
        void'(exp_word.pop_front());
    endtask

    task automatic update_model();
        if (flush) begin
            exp_pc.delete();
            exp_word.delete();
            stale = stale || pend_line;
            exp_offset = 6'd4;
        end else begin
            if (nop_next) begin
                push_word(pend_pc, '0);
                push_word(pend_pc + 32'd4, '0);
            end
            if (data_ok && pend_line && !stale) begin
                for (int i = 0; i < int'(resp.data_num); i++)
                    push_word(pend_pc + XLEN'(4 * i), resp.rdata[i]);
                exp_offset = 6'(4 * int'(resp.data_num));
            end
        end
        if (data_ok) begin
            pend_line = 1'b0;
            stale = 1'b0;
        end
        nop_next = 1'b0;
        if (in_valid && in_allowin) begin
            pend_pc = req.pc;
            nop_next = req.no_inst && !flush;
            pend_line = !nop_next;
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            assert (fetch_offset == exp_offset)
                else report_mismatch($sformatf("fetch_offset %0d, expected %0d",
                    fetch_offset, exp_offset));
            assert (!in_allowin || exp_pc.size() <= QUEUE_DEPTH - LINE_WORDS)
                else report_problem("in_allowin high with less than a line of free entries");
            if (out_valid && ds_allowin)
                check_transfer();
            update_model();
        end
    end

    // downstream stalls come in random stretches
    initial begin
        ds_allowin = 1'b0;
        forever begin
            step_cycle();
            if (drain_all)
                ds_allowin = 1'b1;
            else if (($random(stall_seed) & 3) == 0)
                ds_allowin = !ds_allowin;
        end
    end

    initial begin
        int tries;
        in_valid = 1'b0;
        req = '0;
        data_ok = 1'b0;
        resp = '0;
        flush = 1'b0;
        tries = 0;
        do begin
            @(posedge clk);
            tries++;
            if (tries > 10)
                report_problem("reset was not released");
        end while (reset);
        #10;
        assert (!out_valid && in_allowin)
            else report_problem("out_valid or in_allowin wrong after reset");
        for (int r = 0; r < NUM_REQS; r++) begin
            send_request();
            if (!req.no_inst)
                answer_request();
            // sometimes lands on the cycle of a no-instruction write
            if (($random(seed) & 15) == 0) begin
                flush = 1'b1;
                step_cycle();
                flush = 1'b0;
            end
        end
        drain_all = 1'b1;
        tries = 0;
        while (exp_pc.size() >= 2) begin
            step_cycle();
            tries++;
            if (tries > 100)
                report_problem("queued words were not issued within 100 cycles");
        end
        if (!out_valid) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_problem("out_valid still high with fewer than two words expected");
        end
    end

endmodule

// ==== fetch_stage.f ====
common/fetch_pkg.sv
src/fetch_ctrl.sv
inst_queue/inst_queue.sv
issue/inst_classify.sv
issue/pair_issue.sv
src/fetch_stage.sv
verif/clock_gen.sv
verif/fetch_stage_asserts.sv
verif/tb_fetch_stage.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_fetch_stage -f fetch_stage.f \
    || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Vtb_fetch_stage 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "Testbench passed" && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
